// ==== audio/audio_mixer.sv ====
// sums the three psg channels and the ste dma sound into one signed mix per side
// the registered mix feeds the sigma-delta dac
// psg_stereo_i puts A+B on the left and C+B on the right, else A+B+C on both
`timescale 1ns/1ns
`default_nettype none

module audio_mixer import st_glue_pkg::*; (
	input  wire             clk_32,
	input  wire             xsint,
	input  wire ym_chan_t   ym_a_i,
	input  wire ym_chan_t   ym_b_i,
	input  wire ym_chan_t   ym_c_i,
	input  wire             psg_stereo_i,
	input  wire dma_snd_t   dma_snd_l_i,
	input  wire dma_snd_t   dma_snd_r_i,
	output audio_mix_t      mix_l_o,
	output audio_mix_t      mix_r_o
);

	ym_sum_t    ym_sum_l;
	ym_sum_t    ym_sum_r;
	ym_sum_t    ym_signed_l;
	ym_sum_t    ym_signed_r;
	dma_snd_t   dma_signed_l;
	dma_snd_t   dma_signed_r;
	audio_mix_t mix_l_d;
	audio_mix_t mix_r_d;

	// 10 bit two's complement widened to 15, low bits refilled from the top
	function automatic audio_mix_t ym_scale(input ym_sum_t s);
		return {s[9], s, s[9:6]};
	endfunction

	// 8 bit sample scaled the same way
	function automatic audio_mix_t dma_scale(input dma_snd_t s);
		return {s[7], s, s[7:2]};
	endfunction

	always_comb begin
		if (psg_stereo_i) begin
			ym_sum_l = ym_sum_t'(ym_a_i) + ym_sum_t'(ym_b_i);
			ym_sum_r = ym_sum_t'(ym_c_i) + ym_sum_t'(ym_b_i);
		end else begin
			ym_sum_l = ym_sum_t'(ym_a_i) + ym_sum_t'(ym_b_i) + ym_sum_t'(ym_c_i);
			ym_sum_r = ym_sum_l;  // mono, same on both sides
		end
	end

	// midpoint removal, wraps into two's complement
	assign ym_signed_l  = ym_sum_l - ym_sum_t'(YM_MIDPOINT);
	assign ym_signed_r  = ym_sum_r - ym_sum_t'(YM_MIDPOINT);
	assign dma_signed_l = dma_snd_l_i - dma_snd_t'(DMA_MIDPOINT);
	assign dma_signed_r = dma_snd_r_i - dma_snd_t'(DMA_MIDPOINT);

	assign mix_l_d = ym_scale(ym_signed_l) + dma_scale(dma_signed_l);
	assign mix_r_d = ym_scale(ym_signed_r) + dma_scale(dma_signed_r);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_l_o <= '0;
			mix_r_o <= '0;
		end else begin
			mix_l_o <= mix_l_d;
			mix_r_o <= mix_r_d;
		end
	end

endmodule

`default_nettype wire

// ==== audio/sigma_delta_dac.sv ====
// first order sigma-delta converter, one bitstream per side
// the signed mix is turned to offset binary and added into a 15 bit accumulator,
// the carry out of each add is the output bit
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac import st_glue_pkg::*; (
	input  wire             clk_32,
	input  wire             xsint,
	input  wire audio_mix_t mix_l_i,
	input  wire audio_mix_t mix_r_i,
	output logic            audio_l_o,
	output logic            audio_r_o
);

	logic [14:0] acc_l_q;
	logic [14:0] acc_r_q;
	logic [15:0] sum_l;
	logic [15:0] sum_r;

	// flip the sign bit, 0 becomes midscale
	function automatic logic [14:0] offset_bin(input audio_mix_t m);
		return {~m[14], m[13:0]};
	endfunction

	assign sum_l = {1'b0, acc_l_q} + {1'b0, offset_bin(mix_l_i)};
	assign sum_r = {1'b0, acc_r_q} + {1'b0, offset_bin(mix_r_i)};

	// ones density over 2^15 cycles equals the offset binary value
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc_l_q   <= '0;
			acc_r_q   <= '0;
			audio_l_o <= 1'b0;
			audio_r_o <= 1'b0;
		end else begin
			acc_l_q   <= sum_l[14:0];
			acc_r_q   <= sum_r[14:0];
			audio_l_o <= sum_l[15];  // carry out
			audio_r_o <= sum_r[15];
		end
	end

endmodule

`default_nettype wire

// ==== common/st_glue_pkg.sv ====
// shared widths, sample types and constants of the ST audio and interrupt glue
// every block takes what it needs through a wildcard import in its header
`default_nettype none

package st_glue_pkg;

	// audio sample types
	typedef logic [7:0] ym_chan_t;            // one psg channel, unsigned
	typedef logic [9:0] ym_sum_t;             // two or three channels added
	typedef logic [7:0] dma_snd_t;            // ste dma sample, midpoint 128
	typedef logic signed [14:0] audio_mix_t;  // per side mix into the dac

	localparam int YM_MIDPOINT  = 512;
	localparam int DMA_MIDPOINT = 128;

	// viking card lives at $c00000, address bits 23..18
	localparam logic [5:0] VIKING_PAGE = 6'b110000;

	// enough accesses to trust that the driver is running
	localparam int VIKING_THRESHOLD = 255;

	typedef logic [7:0] viking_cnt_t;

	// mfp timer input conditioning
	localparam int SINT_DELAY_TAPS = 8;   // 74ls164 on the ste board
	localparam int DE_DELAY_TAPS   = 28;  // in 8 MHz bus cycles
	localparam int CLK2_DIVIDE     = 16;  // clk_32 cycles per 2 MHz tick

	typedef logic [$clog2(CLK2_DIVIDE)-1:0] clk2_cnt_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the st glue testbench with verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_tb

verilator --binary --timing --assert -Wno-fatal \
	-f st_glue_top.f --top-module tb_st_glue -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

// ==== src/mfp_timer_inputs.sv ====
// conditions the timer a/b and gpio 7 inputs of the mfp
// timer a is the dma sound interrupt delayed by eight 2 MHz ticks (ste only),
// timer b is display enable delayed by 28 bus cycles
`timescale 1ns/1ns
`default_nettype none

module mfp_timer_inputs import st_glue_pkg::*; (
	input  wire  clk_32,
	input  wire  xsint,
	input  wire  mhz8_en_i,
	input  wire  ste_i,
	input  wire  sound_int_i,
	input  wire  de_i,
	input  wire  mono_detect_i,
	output logic timer_a_o,
	output logic timer_b_o,
	output logic mfp_io7_o
);

	clk2_cnt_t                  div_cnt_q;
	logic                       clk2_en_q;
	logic [SINT_DELAY_TAPS-1:0] sint_dly_q;
	logic                       sint_out_q;
	logic [DE_DELAY_TAPS-1:0]   de_dly_q;

	// 32 MHz down to a one cycle 2 MHz tick
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div_cnt_q <= '0;
			clk2_en_q <= 1'b0;
		end else begin
			clk2_en_q <= (div_cnt_q == '0);
			if (div_cnt_q == clk2_cnt_t'(CLK2_DIVIDE - 1))
				div_cnt_q <= '0;
			else
				div_cnt_q <= div_cnt_q + 1'b1;
		end
	end

	// shift register held clear while the interrupt is low
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			sint_dly_q <= '0;
			sint_out_q <= 1'b0;
		end else begin
			if (!sound_int_i)
				sint_dly_q <= '0;
			else if (clk2_en_q)
				sint_dly_q <= {sint_dly_q[SINT_DELAY_TAPS-2:0], sound_int_i};
			sint_out_q <= sint_dly_q[SINT_DELAY_TAPS-1];
		end
	end

	// display enable, one step per bus cycle
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			de_dly_q <= '0;
		else if (mhz8_en_i)
			de_dly_q <= {de_dly_q[DE_DELAY_TAPS-2:0], de_i};
	end

	// on the st the printer busy line sits here, idle high
	assign timer_a_o = ste_i ? sint_out_q : 1'b1;
	assign timer_b_o = de_dly_q[DE_DELAY_TAPS-1];

	// mono detect, xor'd with the sound irq on the ste
	assign mfp_io7_o = mono_detect_i ^ (ste_i & sound_int_i);

endmodule

`default_nettype wire

// ==== src/st_glue_top.sv ====
// audio and interrupt glue of an ST/STE style system
// psg and dma sound in, sigma-delta bitstreams out, plus the conditioned
// mfp timer inputs and the viking card activity flag
`timescale 1ns/1ns
`default_nettype none

module st_glue_top import st_glue_pkg::*; (
	input  wire           clk_32,
	input  wire           xsint,

	// psg channels and dma sound
	input  wire ym_chan_t ym_a_i,
	input  wire ym_chan_t ym_b_i,
	input  wire ym_chan_t ym_c_i,
	input  wire           psg_stereo_i,
	input  wire dma_snd_t dma_snd_l_i,
	input  wire dma_snd_t dma_snd_r_i,

	// mfp related inputs
	input  wire           ste_i,
	input  wire           sound_int_i,
	input  wire           de_i,
	input  wire           mono_detect_i,
	input  wire           mhz8_en_i,     // one clk_32 in four

	// cpu bus, only what the viking detector needs
	input  wire           as_n_i,
	input  wire [5:0]     cpu_a_hi_i,    // address 23..18
	input  wire           viking_enable_i,

	output wire           audio_l_o,
	output wire           audio_r_o,
	output wire           timer_a_o,
	output wire           timer_b_o,
	output wire           mfp_io7_o,
	output wire           viking_active_o
);

	audio_mix_t mix_l;
	audio_mix_t mix_r;

	audio_mixer u_audio_mixer (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.ym_a_i       (ym_a_i),
		.ym_b_i       (ym_b_i),
		.ym_c_i       (ym_c_i),
		.psg_stereo_i (psg_stereo_i),
		.dma_snd_l_i  (dma_snd_l_i),
		.dma_snd_r_i  (dma_snd_r_i),
		.mix_l_o      (mix_l),
		.mix_r_o      (mix_r)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.clk_32    (clk_32),
		.xsint     (xsint),
		.mix_l_i   (mix_l),
		.mix_r_i   (mix_r),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

	mfp_timer_inputs u_mfp_timer_inputs (
		.clk_32        (clk_32),
		.xsint         (xsint),
		.mhz8_en_i     (mhz8_en_i),
		.ste_i         (ste_i),
		.sound_int_i   (sound_int_i),
		.de_i          (de_i),
		.mono_detect_i (mono_detect_i),
		.timer_a_o     (timer_a_o),
		.timer_b_o     (timer_b_o),
		.mfp_io7_o     (mfp_io7_o)
	);

	viking_detect u_viking_detect (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en_i       (mhz8_en_i),
		.as_n_i          (as_n_i),
		.cpu_a_hi_i      (cpu_a_hi_i),
		.viking_enable_i (viking_enable_i),
		.viking_active_o (viking_active_o)
	);

endmodule

`default_nettype wire

// ==== src/viking_detect.sv ====
// watches cpu accesses to the viking card window at $c0xxxx
// the card counts as in use once the driver has touched it 255 times,
// a few stray probes from other software are not enough
`timescale 1ns/1ns
`default_nettype none

module viking_detect import st_glue_pkg::*; (
	input  wire       clk_32,
	input  wire       xsint,
	input  wire       mhz8_en_i,
	input  wire       as_n_i,
	input  wire [5:0] cpu_a_hi_i,
	input  wire       viking_enable_i,
	output logic      viking_active_o
);

	viking_cnt_t access_cnt_q;
	logic        access_hit;
	logic        cnt_full;

	// one count per bus cycle with the address strobe low
	assign access_hit = mhz8_en_i && !as_n_i && viking_enable_i &&
		(cpu_a_hi_i == VIKING_PAGE);

	assign cnt_full = (access_cnt_q == viking_cnt_t'(VIKING_THRESHOLD));

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			access_cnt_q    <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (access_hit && !cnt_full)
				access_cnt_q <= access_cnt_q + 1'b1;  // saturates at threshold
			viking_active_o <= cnt_full;  // sticky, counter never leaves full
		end
	end

endmodule

`default_nettype wire

// ==== st_glue_top.f ====
common/st_glue_pkg.sv
audio/audio_mixer.sv
audio/sigma_delta_dac.sv
src/mfp_timer_inputs.sv
src/viking_detect.sv
src/st_glue_top.sv
verif/st_glue_properties.sv
verif/st_glue_checker.sv
verif/tb_st_glue.sv

// ==== verif/st_glue_checker.sv ====
// watches the glue top level ports and compares them with expected values
// the testbench top calls its tasks once the stimulus of a case is in place
`timescale 1ns/1ns
`default_nettype none

module st_glue_checker (
	input wire clk_32,
	input wire mhz8_en_i,
	input wire de_i,
	input wire sound_int_i,
	input wire audio_l_o,
	input wire audio_r_o,
	input wire timer_a_o,
	input wire timer_b_o,
	input wire mfp_io7_o,
	input wire viking_active_o
);

	int check_errors;
	int other_errors;

	initial begin
		check_errors = 0;
		other_errors = 0;
	end

	task automatic compare(input string name, input int expected, input int actual);
		if (expected != actual) begin
			check_errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic note_failure(input string what);
		other_errors++;
		$display("ERROR: %s", what);
	endtask

	// ones over one full accumulator period
	task automatic count_ones(input string name, input int exp_l, input int exp_r);
		int ones_l = 0;
		int ones_r = 0;
		repeat (4) @(posedge clk_32);  // dac output settles in 3 cycles
		for (int i = 0; i < 32768; i++) begin
			@(posedge clk_32);
			ones_l += int'(audio_l_o);
			ones_r += int'(audio_r_o);
		end
		compare({name, " left"}, exp_l, ones_l);
		compare({name, " right"}, exp_r, ones_r);
	endtask

	// strobes from the de_i change until timer_b_o follows
	task automatic measure_de_delay(input string name, input logic target, input int expected);
		int strobes = 0;
		int waited = 0;
		bit seen = 0;
		bit done = 0;
		while (!seen && waited < 8) begin
			@(posedge clk_32);
			waited++;
			if (de_i == target)
				seen = 1;
		end
		if (!seen) begin
			note_failure({name, ": de_i never changed"});
		end else begin
			if (mhz8_en_i)
				strobes = 1;  // this edge already shifts the new level in
			waited = 0;
			while (!done && waited < 200) begin
				@(posedge clk_32);
				waited++;
				if (timer_b_o == target)
					done = 1;
				else if (mhz8_en_i)
					strobes++;
			end
			if (!done)
				note_failure({name, ": timed out waiting for timer_b_o"});
			else
				compare(name, expected, strobes);
		end
	endtask

	task automatic measure_timer_a_rise(input string name, input int lo, input int hi);
		int cycles = 0;
		int waited = 0;
		bit seen = 0;
		bit done = 0;
		while (!seen && waited < 8) begin
			@(posedge clk_32);
			waited++;
			seen = sound_int_i;
		end
		while (seen && !done && cycles < 200) begin
			@(posedge clk_32);
			cycles++;
			done = timer_a_o;
		end
		if (!seen)
			note_failure({name, ": sound_int_i never rose"});
		else if (!done)
			note_failure({name, ": timed out waiting for timer_a_o to rise"});
		else if (cycles < lo || cycles > hi) begin
			check_errors++;
			$display("CHECK FAILED %s rise: expected %0d..%0d, actual %0d",
				name, lo, hi, cycles);
		end
	endtask

	task automatic measure_timer_a_fall(input string name, input int max_cycles);
		int cycles = 0;
		int waited = 0;
		bit seen = 0;
		bit done = 0;
		while (!seen && waited < 8) begin
			@(posedge clk_32);
			waited++;
			seen = !sound_int_i;
		end
		while (seen && !done && cycles < 20) begin
			@(posedge clk_32);
			cycles++;
			done = !timer_a_o;
		end
		if (!seen)
			note_failure({name, ": sound_int_i never fell"});
		else if (!done)
			note_failure({name, ": timed out waiting for timer_a_o to fall"});
		else if (cycles > max_cycles) begin
			check_errors++;
			$display("CHECK FAILED %s fall: expected at most %0d, actual %0d",
				name, max_cycles, cycles);
		end
	endtask

	task automatic hold_timer_a(input string name, input int expected, input int cycles);
		int wrong = 0;
		int last = expected;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_32);
			if (int'(timer_a_o) != expected) begin
				wrong++;
				last = int'(timer_a_o);
			end
		end
		if (wrong != 0)
			compare(name, expected, last);
	endtask

	task automatic check_io7(input string name, input int expected);
		@(posedge clk_32);
		compare(name, expected, int'(mfp_io7_o));
	endtask

	task automatic check_viking(input string name, input int expected);
		repeat (4) @(posedge clk_32);
		compare(name, expected, int'(viking_active_o));
	endtask

	// called once per reset cycle
	task automatic check_reset_state(input string name, input int exp_zero, input int exp_ta);
		compare({name, " audio_l_o"}, exp_zero, int'(audio_l_o));
		compare({name, " audio_r_o"}, exp_zero, int'(audio_r_o));
		compare({name, " timer_b_o"}, exp_zero, int'(timer_b_o));
		compare({name, " viking_active_o"}, exp_zero, int'(viking_active_o));
		compare({name, " timer_a_o"}, exp_ta, int'(timer_a_o));
	endtask

endmodule

`default_nettype wire

// ==== verif/st_glue_properties.sv ====
// assertions on the glue top level, attached through bind
// covers the sticky viking flag, the timer a clear and the dac reset state
`timescale 1ns/1ns
`default_nettype none

module st_glue_properties (
	input wire clk_32,
	input wire xsint,
	input wire ste_i,
	input wire sound_int_i,
	input wire timer_a_o,
	input wire audio_l_o,
	input wire audio_r_o,
	input wire viking_active_o
);

	// once active the card stays active until the next reset
	viking_sticky: assert property (@(posedge clk_32) disable iff (!xsint)
		!$fell(viking_active_o))
		else $error("viking_active_o fell without a reset");

	// a low interrupt empties the ste delay line within two cycles
	timer_a_cleared: assert property (@(posedge clk_32) disable iff (!xsint)
		!sound_int_i |-> ##2 (timer_a_o == !ste_i))
		else $error("timer_a_o not at its idle level two cycles after sound_int_i low");

	audio_quiet_in_reset: assert property (@(posedge clk_32)
		!xsint |-> (!audio_l_o && !audio_r_o))
		else $error("audio output active during reset");

endmodule

bind st_glue_top st_glue_properties u_properties (.*);

`default_nettype wire

// ==== verif/st_glue_trace.txt ====
# name kind v0 v1 v2 v3 v4 v5 e0 e1 (decimal)
# MIX: ym_a ym_b ym_c stereo dma_l dma_r, ones per 32768 cycles left right
# TIMB: new de level, strobes. TIMA ste=1: ste fall_max, rise window lo hi
# TIMA ste=0: ste cycles, level. IO7: ste sint mono, io7. VIK: reset en page n, active
# RST: expected level of audio/timer_b/viking, expected timer_a
mix_silence      MIX  0   0   0   0 128 128  8200  8200
mix_dma_split    MIX  0   0   0   0 255   0 16359    40
mix_ym_mid       MIX  170 170 170 0 128 128 16367 16367
mix_ym_full      MIX  255 255 255 0 200 100 25061 18700
stereo_a_heavy   MIX  255 128 0   1 128 128 14333 10250
stereo_c_heavy   MIX  0   200 250 1 128 128 11403 15407
timb_rise        TIMB 1   0   0   0 0   0   28    0
timb_fall        TIMB 0   0   0   0 0   0   28    0
timb_rise_again  TIMB 1   0   0   0 0   0   28    0
tima_ste         TIMA 1   2   0   0 0   0   114   129
tima_ste_again   TIMA 1   2   0   0 0   0   114   129
tima_st_idle     TIMA 0   300 0   0 0   0   1     0
io7_st_mono      IO7  0   1   1   0 0   0   1     0
io7_st_color     IO7  0   1   0   0 0   0   0     0
io7_ste_irq      IO7  1   1   0   0 0   0   1     0
io7_ste_irq_mono IO7  1   1   1   0 0   0   0     0
io7_ste_quiet    IO7  1   0   1   0 0   0   1     0
io7_ste_none     IO7  1   0   0   0 0   0   0     0
vik_disabled     VIK  1   0   48  300 0 0   0     0
vik_other_page   VIK  1   1   49  300 0 0   0     0
vik_254          VIK  1   1   48  254 0 0   0     0
vik_255          VIK  0   1   48  1   0 0   1     0
rst_mid_run      RST  0   0   0   0 0   0   0     1
vik_after_reset  VIK  0   1   48  0   0 0   0     0

// ==== verif/tb_st_glue.sv ====
// testbench for the st glue top level
// reads cases from verif/st_glue_trace.txt, drives them and lets the checker compare
`timescale 1ns/1ns
`default_nettype none

module tb_st_glue;

	logic       clk_32;
	logic       xsint;
	logic [7:0] ym_a_i;
	logic [7:0] ym_b_i;
	logic [7:0] ym_c_i;
	logic       psg_stereo_i;
	logic [7:0] dma_snd_l_i;
	logic [7:0] dma_snd_r_i;
	logic       ste_i;
	logic       sound_int_i;
	logic       de_i;
	logic       mono_detect_i;
	logic       mhz8_en_i;
	logic       as_n_i;
	logic [5:0] cpu_a_hi_i;
	logic       viking_enable_i;
	wire        audio_l_o;
	wire        audio_r_o;
	wire        timer_a_o;
	wire        timer_b_o;
	wire        mfp_io7_o;
	wire        viking_active_o;

	logic [1:0] phase;
	int         fd;
	int         fields;
	int         seed;
	int         idle;
	int         cases;
	int         total;
	string      line;
	string      tname;
	string      kind;
	int         v0;
	int         v1;
	int         v2;
	int         v3;
	int         v4;
	int         v5;
	int         e0;
	int         e1;

	st_glue_top UUT (.*);

	st_glue_checker u_checker (
		.clk_32          (clk_32),
		.mhz8_en_i       (mhz8_en_i),
		.de_i            (de_i),
		.sound_int_i     (sound_int_i),
		.audio_l_o       (audio_l_o),
		.audio_r_o       (audio_r_o),
		.timer_a_o       (timer_a_o),
		.timer_b_o       (timer_b_o),
		.mfp_io7_o       (mfp_io7_o),
		.viking_active_o (viking_active_o)
	);

	always #5 clk_32 = ~clk_32;

	// 8 MHz bus strobe on one clk_32 in four
	always @(posedge clk_32) begin
		phase     <= phase + 2'd1;
		mhz8_en_i <= (phase == 2'd3);
	end

	task automatic apply_reset(input string name, input bit check, input int exp_zero,
		input int exp_ta);
		@(posedge clk_32);
		ste_i       <= 1'b0;
		sound_int_i <= 1'b0;
		xsint       <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_32);
			if (check)
				u_checker.check_reset_state(name, exp_zero, exp_ta);
		end
		xsint <= 1'b1;
	endtask

	// holds a card access for n bus strobes
	task automatic viking_access(input string name, input int en, input int page, input int n);
		int counted = 0;
		int waited = 0;
		@(posedge clk_32);
		viking_enable_i <= en[0];
		cpu_a_hi_i      <= 6'(page);
		as_n_i          <= 1'b0;
		while (counted < n && waited < 4 * n + 16) begin
			@(posedge clk_32);
			waited++;
			if (mhz8_en_i)
				counted++;
		end
		as_n_i          <= 1'b1;
		viking_enable_i <= 1'b0;
		if (counted < n)
			u_checker.note_failure({name, ": timed out counting bus strobes"});
	endtask

	task automatic run_case();
		if (kind == "MIX") begin
			@(posedge clk_32);
			ym_a_i       <= 8'(v0);
			ym_b_i       <= 8'(v1);
			ym_c_i       <= 8'(v2);
			psg_stereo_i <= v3[0];
			dma_snd_l_i  <= 8'(v4);
			dma_snd_r_i  <= 8'(v5);
			u_checker.count_ones(tname, e0, e1);
		end else if (kind == "TIMB") begin
			@(posedge clk_32);
			de_i <= v0[0];
			u_checker.measure_de_delay(tname, v0[0], e0);
		end else if (kind == "TIMA" && v0 != 0) begin
			@(posedge clk_32);
			ste_i       <= 1'b1;
			sound_int_i <= 1'b0;
			repeat (4) @(posedge clk_32);
			sound_int_i <= 1'b1;
			u_checker.measure_timer_a_rise(tname, e0, e1);
			@(posedge clk_32);
			sound_int_i <= 1'b0;
			u_checker.measure_timer_a_fall(tname, v1);
		end else if (kind == "TIMA") begin
			@(posedge clk_32);
			ste_i       <= 1'b0;
			sound_int_i <= 1'b1;
			u_checker.hold_timer_a(tname, e0, v1);
			@(posedge clk_32);
			sound_int_i <= 1'b0;
		end else if (kind == "IO7") begin
			@(posedge clk_32);
			ste_i         <= v0[0];
			sound_int_i   <= v1[0];
			mono_detect_i <= v2[0];
			u_checker.check_io7(tname, e0);
			@(posedge clk_32);
			sound_int_i <= 1'b0;
		end else if (kind == "VIK") begin
			if (v0 != 0)
				apply_reset(tname, 1'b0, 0, 1);
			viking_access(tname, v1, v2, v3);
			u_checker.check_viking(tname, e0);
		end else if (kind == "RST") begin
			apply_reset(tname, 1'b1, e0, e1);
		end else begin
			u_checker.note_failure({"unknown case kind ", kind, " in trace"});
		end
	endtask

	initial begin
		clk_32          = 1'b0;
		xsint           = 1'b1;
		ym_a_i          = '0;
		ym_b_i          = '0;
		ym_c_i          = '0;
		psg_stereo_i    = 1'b0;
		dma_snd_l_i     = 8'd128;
		dma_snd_r_i     = 8'd128;
		ste_i           = 1'b0;
		sound_int_i     = 1'b0;
		de_i            = 1'b0;
		mono_detect_i   = 1'b0;
		mhz8_en_i       = 1'b0;
		as_n_i          = 1'b1;
		cpu_a_hi_i      = '0;
		viking_enable_i = 1'b0;
		phase           = '0;
		cases           = 0;
		seed            = 65803;
		void'($urandom(seed));

		apply_reset("power_on", 1'b1, 0, 1);

		fd = $fopen("verif/st_glue_trace.txt", "r");
		if (fd == 0) begin
			u_checker.note_failure("could not open verif/st_glue_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				fields = $fgets(line, fd);
				if (line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%s %s %d %d %d %d %d %d %d %d",
						tname, kind, v0, v1, v2, v3, v4, v5, e0, e1);
					if (fields == 10) begin
						run_case();
						cases++;
					end else begin
						u_checker.note_failure({"malformed trace line: ", line});
					end
					idle = int'($urandom % 8);  // filler between cases
					repeat (idle) @(posedge clk_32);
				end
			end
			$fclose(fd);
		end
		if (cases == 0)
			u_checker.note_failure("no test cases were run");

		total = u_checker.check_errors + u_checker.other_errors;
		$display("%0d cases, %0d value mismatches, %0d other errors", cases,
			u_checker.check_errors, u_checker.other_errors);
		if (total == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
